//--- spis_pkg.sv
// Serial protocol definitions for the SPI slave
// Mode 0 only, MSB first, one 32-bit word per command
// Opcodes other than read and write are dropped by the frame stage

package spis_pkg;

  //////////////////////////////////////////////////////////////////////
  // Command opcode, upper nibble of the command byte
  //////////////////////////////////////////////////////////////////////
  typedef enum logic [3:0] {
    OP_READ  = 4'd1,
    OP_WRITE = 4'd2
  } opcode_t;

  // Frame phases
  typedef enum logic [2:0] {
    ST_IDLE,
    ST_CMD,
    ST_ADDR,
    ST_WDATA,
    ST_WIDLE,
    ST_RWAIT,
    ST_RDATA
  } frame_st_t;

  // Bit position inside one phase, wide enough for 32
  typedef logic [5:0] bitcnt_t;

  // Phase lengths in sclk periods
  localparam int CMD_BITS  = 8;
  localparam int ADDR_BITS = 32;
  localparam int DATA_BITS = 32;
  localparam int WAIT_BITS = 8;

endpackage

//--- wb_pkg.sv
// Internal Wishbone classic bus widths
// Byte addressed, 32-bit data, four byte lanes
// Bank size default applies when the top level does not override it

package wb_pkg;

  // Byte address
  typedef logic [31:0] addr_t;

  // Data word
  typedef logic [31:0] data_t;

  // Byte lane enables, bit n covers data bits 8n+7 down to 8n
  typedef logic [3:0]  sel_t;

  // Register count of the bank, power of two
  localparam int REG_WORDS_DEF = 16;

endpackage

//--- spis_ifs.sv
// Interfaces between the pipeline stages
// All signals live in the sys_clk domain
// Request is a level held until ack, ack is a single-cycle pulse

`timescale 1ns/1ps

//////////////////////////////////////////////////////////////////////
// Capture to frame stage
//////////////////////////////////////////////////////////////////////
interface spis_edge_if;
  // One-cycle pulses per sclk edge
  logic sck_rise;
  logic sck_fall;
  // Synchronized select, high while ssn is low
  logic sel_active;
  // Synchronized serial input
  logic sdin_s;

  modport producer (output sck_rise, sck_fall, sel_active, sdin_s);
  modport consumer (input  sck_rise, sck_fall, sel_active, sdin_s);
endinterface

//////////////////////////////////////////////////////////////////////
// Frame stage to bus stage request
//////////////////////////////////////////////////////////////////////
interface spis_req_if;
  import wb_pkg::*;

  logic  wr;
  logic  rd;
  addr_t addr;
  sel_t  be;
  data_t wdata;
  // Returned by the bus stage
  data_t rdata;
  logic  ack;

  modport frame (output wr, rd, addr, be, wdata, input  rdata, ack);
  modport bus   (input  wr, rd, addr, be, wdata, output rdata, ack);
endinterface

//////////////////////////////////////////////////////////////////////
// Wishbone classic, no ERR or RTY
//////////////////////////////////////////////////////////////////////
interface wb_if;
  import wb_pkg::*;

  logic  cyc;
  logic  stb;
  logic  we;
  addr_t adr;
  sel_t  sel;
  data_t dat_w;
  data_t dat_r;
  logic  ack;

  modport master (output cyc, stb, we, adr, sel, dat_w, input  dat_r, ack);
  modport slave  (input  cyc, stb, we, adr, sel, dat_w, output dat_r, ack);
endinterface

//--- spis_capture.sv
// Pin synchronizers and sclk edge detection
// sclk must run at sys_clk / 8 or slower
// sel_active and sdin_s lag the pins by 2 cycles, edge pulses by 3

`timescale 1ns/1ps

module spis_capture (
  input  logic          sys_clk,
  input  logic          rst_n,
  input  logic          sclk,
  input  logic          ssn,
  input  logic          sdin,
  spis_edge_if.producer edge_o
);

  // Two-flop synchronizer chains, bit 1 is the stable output
  logic [1:0] sclk_sync;
  logic [1:0] ssn_sync;
  logic [1:0] sdin_sync;
  // Delayed copy of the synchronized sclk
  logic       sclk_d;

  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      // Idle levels, sclk and ssn high
      sclk_sync       <= 2'b11;
      ssn_sync        <= 2'b11;
      sdin_sync       <= 2'b00;
      sclk_d          <= 1'b1;
      edge_o.sck_rise <= 1'b0;
      edge_o.sck_fall <= 1'b0;
    end else begin
      sclk_sync       <= {sclk_sync[0], sclk};
      ssn_sync        <= {ssn_sync[0], ssn};
      sdin_sync       <= {sdin_sync[0], sdin};
      sclk_d          <= sclk_sync[1];
      // Registered edge pulses
      edge_o.sck_rise <= sclk_sync[1] & ~sclk_d;
      edge_o.sck_fall <= ~sclk_sync[1] & sclk_d;
    end
  end

  // Active select is ssn low
  assign edge_o.sel_active = ~ssn_sync[1];
  assign edge_o.sdin_s     = sdin_sync[1];

endmodule

//--- spis_frame.sv
// Frame decoder, serial shift registers and sdout driver
// Command byte, 32-bit address, then write data or wait bits and read data
// ssn must stay low until after the last sclk falling edge of a frame
// Read data must return within the 8 wait bits, given the sclk limit

`timescale 1ns/1ps

module spis_frame (
  input  logic            sys_clk,
  input  logic            rst_n,
  spis_edge_if.consumer   edge_i,
  spis_req_if.frame       req,
  output logic            sdout,
  output logic            sdout_oen
);
  import spis_pkg::*;
  import wb_pkg::*;

  frame_st_t           state;
  bitcnt_t             bitcnt;
  // Index of the final bit of the current phase
  bitcnt_t             last_idx;
  logic                last_bit;
  logic [CMD_BITS-1:0] cmd_q;
  opcode_t             opcode;
  addr_t               addr_q;
  data_t               wdata_q;
  data_t               rd_shift;

  //////////////////////////////////////////////////////////////////////
  // Phase length lookup
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    case (state)
      ST_ADDR:            last_idx = bitcnt_t'(ADDR_BITS - 1);
      ST_WDATA, ST_RDATA: last_idx = bitcnt_t'(DATA_BITS - 1);
      ST_WIDLE, ST_RWAIT: last_idx = bitcnt_t'(WAIT_BITS - 1);
      default:            last_idx = bitcnt_t'(CMD_BITS - 1);
    endcase
  end

  assign last_bit = (bitcnt == last_idx);
  assign opcode   = opcode_t'(cmd_q[CMD_BITS-1:CMD_BITS-4]);

  // Request payload straight from the shift registers
  assign req.addr  = addr_q;
  assign req.be    = sel_t'(cmd_q[3:0]);
  assign req.wdata = wdata_q;

  //////////////////////////////////////////////////////////////////////
  // Shift registers
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge sys_clk) begin
    // Inbound bits on sclk rise
    if (edge_i.sck_rise) begin
      if (state == ST_CMD) begin
        cmd_q <= {cmd_q[CMD_BITS-2:0], edge_i.sdin_s};
      end
      if (state == ST_ADDR) begin
        addr_q <= {addr_q[$bits(addr_t)-2:0], edge_i.sdin_s};
      end
      if (state == ST_WDATA) begin
        wdata_q <= {wdata_q[DATA_BITS-2:0], edge_i.sdin_s};
      end
    end
    // Read word arrives during the wait bits
    if (req.ack && req.rd) begin
      rd_shift <= req.rdata;
    end else if (state == ST_RDATA && edge_i.sck_fall) begin
      rd_shift <= {rd_shift[DATA_BITS-2:0], 1'b0};
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Frame FSM
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= ST_IDLE;
      bitcnt    <= '0;
      req.wr    <= 1'b0;
      req.rd    <= 1'b0;
      sdout     <= 1'b0;
      sdout_oen <= 1'b1;
    end else if (!edge_i.sel_active) begin
      // Deselect aborts the frame and releases sdout
      state     <= ST_IDLE;
      bitcnt    <= '0;
      req.wr    <= 1'b0;
      req.rd    <= 1'b0;
      sdout_oen <= 1'b1;
    end else begin
      // Request ends the cycle after ack
      if (req.ack) begin
        req.wr <= 1'b0;
        req.rd <= 1'b0;
      end
      // Next data bit, MSB first
      if (state == ST_RDATA && edge_i.sck_fall) begin
        sdout <= rd_shift[DATA_BITS-1];
      end
      if (state == ST_IDLE) begin
        state  <= ST_CMD;
        bitcnt <= '0;
      end else if (edge_i.sck_rise) begin
        bitcnt <= last_bit ? '0 : bitcnt + 1'b1;
        if (last_bit) begin
          case (state)
            ST_CMD:   state <= ST_ADDR;
            ST_ADDR: begin
              // Opcode decode once the address is complete
              if (opcode == OP_READ) begin
                req.rd <= 1'b1;
                state  <= ST_RWAIT;
              end else if (opcode == OP_WRITE) begin
                state  <= ST_WDATA;
              end else begin
                state  <= ST_CMD;
              end
            end
            ST_WDATA: begin
              req.wr <= 1'b1;
              state  <= ST_WIDLE;
            end
            ST_WIDLE: state <= ST_CMD;
            ST_RWAIT: begin
              // Drive from the last wait bit on
              sdout_oen <= 1'b0;
              state     <= ST_RDATA;
            end
            ST_RDATA: begin
              sdout_oen <= 1'b1;
              state     <= ST_CMD;
            end
            default:  state <= ST_IDLE;
          endcase
        end
      end
    end
  end

  // Request kinds are exclusive
  assert property (@(posedge sys_clk) disable iff (!rst_n) !(req.wr && req.rd))
    else $error("spis_frame: wr and rd high together");

  // Output only enabled around the read data phase
  assert property (@(posedge sys_clk) disable iff (!rst_n)
    (state != ST_RDATA && state != ST_RWAIT) |-> sdout_oen)
    else $error("spis_frame: sdout_oen low outside read phase");

endmodule

//--- spis_wb_master.sv
// Request to Wishbone classic bridge
// One bus cycle per rising edge of a request level
// A started cycle always completes, even if the request drops early

`timescale 1ns/1ps

module spis_wb_master (
  input  logic     sys_clk,
  input  logic     rst_n,
  spis_req_if.bus  req,
  wb_if.master     wb
);
  import wb_pkg::*;

  logic  req_lvl;
  // Edge guard, last cycle's request level
  logic  req_seen;
  logic  pending;
  logic  cyc_q;
  logic  stb_q;
  logic  ack_q;
  logic  we_q;
  addr_t adr_q;
  sel_t  sel_q;
  data_t dat_w_q;
  data_t rdata_q;

  assign req_lvl = req.wr | req.rd;
  // New request, bus idle
  assign pending = req_lvl & ~req_seen & ~cyc_q;

  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      req_seen <= 1'b0;
      cyc_q    <= 1'b0;
      stb_q    <= 1'b0;
      ack_q    <= 1'b0;
    end else begin
      req_seen <= req_lvl;
      ack_q    <= 1'b0;
      if (pending) begin
        cyc_q <= 1'b1;
        stb_q <= 1'b1;
      end else if (cyc_q && wb.ack) begin
        // End of cycle, answer the frame stage
        cyc_q <= 1'b0;
        stb_q <= 1'b0;
        ack_q <= 1'b1;
      end
    end
  end

  // Bus payload held for the whole cycle
  always_ff @(posedge sys_clk) begin
    if (pending) begin
      we_q    <= req.wr;
      adr_q   <= req.addr;
      sel_q   <= req.be;
      dat_w_q <= req.wdata;
    end
    if (cyc_q && wb.ack) begin
      rdata_q <= wb.dat_r;
    end
  end

  assign wb.cyc    = cyc_q;
  assign wb.stb    = stb_q;
  assign wb.we     = we_q;
  assign wb.adr    = adr_q;
  assign wb.sel    = sel_q;
  assign wb.dat_w  = dat_w_q;
  assign req.rdata = rdata_q;
  assign req.ack   = ack_q;

  assert property (@(posedge sys_clk) disable iff (!rst_n) wb.stb |-> wb.cyc)
    else $error("spis_wb_master: stb without cyc");

endmodule

//--- spis_reg_bank.sv
// Wishbone classic register bank, REG_WORDS 32-bit words
// REG_WORDS must be a power of two from 2 to 256
// Out-of-range accesses are acked, read as zero and write nothing

`timescale 1ns/1ps

module spis_reg_bank #(
  parameter int REG_WORDS = wb_pkg::REG_WORDS_DEF
) (
  input  logic sys_clk,
  input  logic rst_n,
  wb_if.slave  wb
);
  import wb_pkg::*;

  localparam int IDX_W = $clog2(REG_WORDS);

  data_t            regs [REG_WORDS];
  logic [IDX_W-1:0] idx;
  logic             in_range;
  logic             access;
  logic             ack_q;
  data_t            dat_r_q;

  // Word index from address bits above bit 1
  assign idx      = wb.adr[IDX_W+1:2];
  assign in_range = (wb.adr[$bits(addr_t)-1:IDX_W+2] == '0);
  // First cycle of a bus access
  assign access   = wb.cyc & wb.stb & ~ack_q;

  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < REG_WORDS; i++) begin
        regs[i] <= '0;
      end
      ack_q <= 1'b0;
    end else begin
      // Self-clearing single-cycle ack
      ack_q <= access;
      if (access && wb.we && in_range) begin
        for (int b = 0; b < $bits(sel_t); b++) begin
          if (wb.sel[b]) begin
            regs[idx][8*b +: 8] <= wb.dat_w[8*b +: 8];
          end
        end
      end
    end
  end

  // Read word valid together with ack
  always_ff @(posedge sys_clk) begin
    if (access) begin
      dat_r_q <= in_range ? regs[idx] : '0;
    end
  end

  assign wb.ack   = ack_q;
  assign wb.dat_r = dat_r_q;

  assert property (@(posedge sys_clk) disable iff (!rst_n) wb.ack |=> !wb.ack)
    else $error("spis_reg_bank: ack held for two cycles");

endmodule

//--- spis_top.sv
// SPI slave to register bank bridge, mode 0, MSB first
// sclk must run at sys_clk / 8 or slower
// sdout_oen is active low, sdout is only valid while it is low

`timescale 1ns/1ps

module spis_top #(
  parameter int REG_WORDS = wb_pkg::REG_WORDS_DEF
) (
  input  logic sys_clk,
  input  logic rst_n,
  input  logic sclk,
  input  logic ssn,
  input  logic sdin,
  output logic sdout,
  output logic sdout_oen
);

  //////////////////////////////////////////////////////////////////////
  // Stage links
  //////////////////////////////////////////////////////////////////////
  spis_edge_if u_edge_if ();
  spis_req_if  u_req_if ();
  wb_if        u_wb_if ();

  // Pin sync and sclk edges
  spis_capture u_capture (
    .sys_clk (sys_clk),
    .rst_n   (rst_n),
    .sclk    (sclk),
    .ssn     (ssn),
    .sdin    (sdin),
    .edge_o  (u_edge_if)
  );

  // Frame decode and serial output
  spis_frame u_frame (
    .sys_clk   (sys_clk),
    .rst_n     (rst_n),
    .edge_i    (u_edge_if),
    .req       (u_req_if),
    .sdout     (sdout),
    .sdout_oen (sdout_oen)
  );

  spis_wb_master u_wb_master (
    .sys_clk (sys_clk),
    .rst_n   (rst_n),
    .req     (u_req_if),
    .wb      (u_wb_if)
  );

  spis_reg_bank #(
    .REG_WORDS (REG_WORDS)
  ) u_reg_bank (
    .sys_clk (sys_clk),
    .rst_n   (rst_n),
    .wb      (u_wb_if)
  );

endmodule

//--- tb_clk_gen.sv
// Testbench clock and reset source
// 100 ns sys_clk period, rst_n low for the first 3 rising edges

`timescale 1ns/1ps

module tb_clk_gen (
  output logic sys_clk,
  output logic rst_n
);

  initial begin
    sys_clk = 1'b0;
    forever #50 sys_clk = ~sys_clk;
  end

  // Release on a rising edge
  initial begin
    rst_n = 1'b0;
    repeat (3) @(posedge sys_clk);
    rst_n <= 1'b1;
  end

endmodule

//--- tb_spis_top.sv
// Testbench for the SPI slave register bridge
// Frames are bit-banged in mode 0 at 16 sys_clk cycles per sclk period
// Bank model assumes REG_WORDS of 16 and word-aligned addresses

`timescale 1ns/1ps

module tb_spis_top;
  import spis_pkg::*;
  import wb_pkg::*;

  localparam int          TB_WORDS = 16;
  localparam int          HALF_SCK = 8;
  localparam int          WAIT_MAX = 400;
  localparam logic [31:0] SEED     = 32'h48f94efd;

  logic  sys_clk;
  logic  rst_n;
  logic  sclk;
  logic  ssn;
  logic  sdin;
  logic  sdout;
  logic  sdout_oen;
  data_t model_mem [TB_WORDS];
  // Collected read words waiting for the compare process
  data_t got_q [$];
  data_t exp_q [$];
  addr_t adr_q [$];
  int    errors;
  int    mark;
  int    failed_tests;
  int    reads_checked;

  tb_clk_gen u_clk_gen (.sys_clk(sys_clk), .rst_n(rst_n));

  spis_top #(.REG_WORDS(TB_WORDS)) u_spis_top (
    .sys_clk   (sys_clk),
    .rst_n     (rst_n),
    .sclk      (sclk),
    .ssn       (ssn),
    .sdin      (sdin),
    .sdout     (sdout),
    .sdout_oen (sdout_oen)
  );

  //////////////////////////////////////////////////////////////////////
  // Bank reference model
  //////////////////////////////////////////////////////////////////////
  // Returns the read word or the merged word on a write
  function automatic data_t bank_model(addr_t adr, logic we, sel_t be, data_t wdata);
    data_t word;
    int    idx;
    idx  = int'(adr >> 2);
    word = '0;
    // Out of range reads zero and writes nothing
    if (adr < addr_t'(TB_WORDS * 4)) begin
      word = model_mem[idx];
      if (we) begin
        for (int b = 0; b < 4; b++) begin
          if (be[b]) begin
            word[8*b +: 8] = wdata[8*b +: 8];
          end
        end
        model_mem[idx] = word;
      end
    end
    return word;
  endfunction

  function automatic addr_t rand_addr();
    return addr_t'($urandom_range(TB_WORDS - 1, 0)) << 2;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Serial driver
  //////////////////////////////////////////////////////////////////////
  // One sclk period with outputs sampled just before the rising edge
  task automatic sck_bit(input logic din, output logic dout, output logic oen);
    @(posedge sys_clk);
    sclk <= 1'b0;
    sdin <= din;
    repeat (HALF_SCK - 1) @(posedge sys_clk);
    @(negedge sys_clk);
    dout = sdout;
    oen  = sdout_oen;
    @(posedge sys_clk);
    sclk <= 1'b1;
    repeat (HALF_SCK - 1) @(posedge sys_clk);
  endtask

  // MSB first with sdout_oen checked on every bit
  task automatic shift(input logic [31:0] value, input int nbits, input logic exp_oen,
                       output logic [31:0] got);
    logic dout;
    logic oen;
    got = '0;
    for (int i = nbits - 1; i >= 0; i--) begin
      sck_bit(value[i], dout, oen);
      got[i] = dout;
      if (oen !== exp_oen) begin
        $display("Mismatch at %0t: sdout_oen got %b expected %b", $time, oen, exp_oen);
        errors++;
      end
    end
  endtask

  task automatic wait_oen(input logic level);
    int n;
    n = 0;
    while (sdout_oen !== level && n < WAIT_MAX) begin
      @(negedge sys_clk);
      n++;
    end
    if (sdout_oen !== level) begin
      $display("Error at %0t: timed out waiting for sdout_oen to go %b", $time, level);
      errors++;
    end
  endtask

  task automatic begin_frame();
    @(posedge sys_clk);
    sclk <= 1'b0;
    ssn  <= 1'b0;
    // Select settles before the first bit
    repeat (HALF_SCK) @(posedge sys_clk);
  endtask

  // Return sclk low then deselect and watch the idle output enable
  task automatic end_frame();
    @(posedge sys_clk);
    sclk <= 1'b0;
    repeat (HALF_SCK) @(posedge sys_clk);
    ssn <= 1'b1;
    wait_oen(1'b1);
    repeat (2 * HALF_SCK) begin
      @(negedge sys_clk);
      if (sdout_oen !== 1'b1) begin
        $display("Mismatch at %0t: sdout_oen got %b expected 1", $time, sdout_oen);
        errors++;
      end
    end
  endtask

  task automatic send_write(input addr_t adr, input sel_t be, input data_t wdata);
    logic [31:0] rx;
    shift({24'd0, OP_WRITE, be}, CMD_BITS, 1'b1, rx);
    shift(adr, ADDR_BITS, 1'b1, rx);
    shift(wdata, DATA_BITS, 1'b1, rx);
    shift('0, WAIT_BITS, 1'b1, rx);
    void'(bank_model(adr, 1'b1, be, wdata));
  endtask

  task automatic send_read(input addr_t adr);
    logic [31:0] rx;
    shift({24'd0, OP_READ, 4'hf}, CMD_BITS, 1'b1, rx);
    shift(adr, ADDR_BITS, 1'b1, rx);
    // Output enable drops on the last wait bit
    shift('0, WAIT_BITS, 1'b1, rx);
    wait_oen(1'b0);
    shift('0, DATA_BITS, 1'b0, rx);
    got_q.push_back(rx);
    exp_q.push_back(bank_model(adr, 1'b0, '0, '0));
    adr_q.push_back(adr);
  endtask

  task automatic write_frame(input addr_t adr, input sel_t be, input data_t wdata);
    begin_frame();
    send_write(adr, be, wdata);
    end_frame();
  endtask

  task automatic read_frame(input addr_t adr);
    begin_frame();
    send_read(adr);
    end_frame();
  endtask

  // Waits for all reads to be compared and then reports the test
  task automatic finish_test(input int num, input string name);
    int n;
    n = 0;
    while (got_q.size() > 0 && n < WAIT_MAX) begin
      @(negedge sys_clk);
      n++;
    end
    if (got_q.size() > 0) begin
      $display("Error at %0t: read words were never compared", $time);
      errors++;
    end
    if (errors == mark) begin
      $display("Test %0d %s: ok", num, name);
    end else begin
      $display("Test %0d %s: failed with %0d errors", num, name, errors - mark);
      failed_tests++;
    end
    mark = errors;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Compare process
  //////////////////////////////////////////////////////////////////////
  initial begin : compare_proc
    data_t got;
    data_t exp;
    addr_t adr;
    forever begin
      @(posedge sys_clk);
      while (got_q.size() > 0) begin
        got = got_q.pop_front();
        exp = exp_q.pop_front();
        adr = adr_q.pop_front();
        reads_checked++;
        if (got !== exp) begin
          $display("Mismatch at %0t: sdout word at %h got %h expected %h",
                   $time, adr, got, exp);
          errors++;
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////
  initial begin : main_proc
    addr_t a;
    addr_t list [6];
    data_t d;
    int    n;
    sclk          = 1'b0;
    ssn           = 1'b1;
    sdin          = 1'b0;
    errors        = 0;
    mark          = 0;
    failed_tests  = 0;
    reads_checked = 0;
    for (int i = 0; i < TB_WORDS; i++) begin
      model_mem[i] = '0;
    end
    n = 0;
    while (rst_n !== 1'b1 && n < WAIT_MAX) begin
      @(posedge sys_clk);
      n++;
    end
    if (rst_n !== 1'b1) begin
      $display("Error at %0t: reset never released", $time);
      errors++;
    end
    void'($urandom(SEED));
    repeat (4) @(posedge sys_clk);

    // Full words and then read back
    for (int i = 0; i < 6; i++) begin
      list[i] = rand_addr();
      write_frame(list[i], 4'hf, $urandom());
    end
    for (int i = 0; i < 6; i++) begin
      read_frame(list[i]);
    end
    finish_test(1, "write and read back");

    // Partial byte lanes
    for (int i = 0; i < 6; i++) begin
      a = rand_addr();
      write_frame(a, sel_t'($urandom_range(15, 0)), $urandom());
      read_frame(a);
    end
    finish_test(2, "byte enables");

    // Nonzero word 0 that an aliased read above the bank would return
    write_frame('0, 4'hf, $urandom() | 32'h1);
    // Beyond the bank with every word left intact
    read_frame(addr_t'(TB_WORDS * 4));
    a = ($urandom() & 32'hffff_fffc) | addr_t'(TB_WORDS * 4);
    write_frame(addr_t'(TB_WORDS * 4), 4'hf, $urandom());
    write_frame(a, 4'hf, $urandom());
    read_frame(a);
    for (int i = 0; i < TB_WORDS; i++) begin
      read_frame(addr_t'(i * 4));
    end
    finish_test(3, "out of range");

    // Write and opcode 5 and read in one select
    a = rand_addr();
    begin_frame();
    send_write(a, 4'hf, $urandom());
    shift({24'd0, 4'h5, 4'hf}, CMD_BITS, 1'b1, d);
    shift(a, ADDR_BITS, 1'b1, d);
    send_read(a);
    end_frame();
    finish_test(4, "commands in one select");

    // Deselect halfway through the write data
    a = rand_addr();
    write_frame(a, 4'hf, $urandom());
    d = $urandom();
    begin_frame();
    shift({24'd0, OP_WRITE, 4'hf}, CMD_BITS, 1'b1, list[0]);
    shift(a, ADDR_BITS, 1'b1, list[0]);
    shift(d >> 16, 16, 1'b1, list[0]);
    end_frame();
    read_frame(a);
    write_frame(a, 4'hf, d);
    read_frame(a);
    finish_test(5, "abort");

    // Output enable high while idle and writing and low for read data
    repeat (4 * HALF_SCK) begin
      @(negedge sys_clk);
      if (sdout_oen !== 1'b1) begin
        $display("Mismatch at %0t: sdout_oen got %b expected 1", $time, sdout_oen);
        errors++;
      end
    end
    a = rand_addr();
    write_frame(a, 4'hf, $urandom());
    read_frame(a);
    finish_test(6, "output enable");

    $display("Summary: 6 tests, %0d failed, %0d reads checked, %0d errors",
             failed_tests, reads_checked, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- build.f
spis_pkg.sv
wb_pkg.sv
spis_ifs.sv
spis_capture.sv
spis_frame.sv
spis_wb_master.sv
spis_reg_bank.sv
spis_top.sv
tb_clk_gen.sv
tb_spis_top.sv
